//--- compile.f
hw/regscore_pkg.sv
hw/dispatch_slots.sv
hw/reg_source_table.sv
hw/reg_valid_tracker.sv
hw/scoreboard_apb.sv
hw/reg_scoreboard_top.sv
tb/tb_reg_scoreboard.sv

//--- hw/dispatch_slots.sv
// Dispatch stage of the scoreboard; picks queued slots, hands out queue tags and registers writes
`timescale 1ns/1ps
`default_nettype none

module dispatch_slots #(
	parameter int areg_count = 64,
	parameter int qentry_count = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic [regscore_pkg::num_slots-1:0] slot_v,
	input  logic [regscore_pkg::num_slots-1:0] slot_rfw,
	input  logic [regscore_pkg::num_slots-1:0] slot_jc,
	input  logic [regscore_pkg::num_slots-1:0][$clog2(areg_count)-1:0] slot_rd,
	input  logic [1:0] free_cnt,
	input  logic branchmiss,
	output logic [1:0] queued_cnt,
	output logic [regscore_pkg::num_slots-1:0] disp_we,
	output logic [regscore_pkg::num_slots-1:0][$clog2(areg_count)-1:0] disp_rd,
	output logic [regscore_pkg::num_slots-1:0][$clog2(qentry_count)-1:0] disp_tag
);

	localparam int ns = regscore_pkg::num_slots;
	localparam int rw = $clog2(areg_count);
	localparam int qw = $clog2(qentry_count);

	// Queue tail, the tag the next queued slot receives
	logic [qw-1:0] tail;

	// Per-slot selection and the position of each chosen slot in queue order
	logic [ns-1:0] sel;
	logic [ns-1:0][1:0] ofs;
	logic [1:0] cnt;
	logic stop;

	// Register writes of this cycle before they are held
	logic [ns-1:0] wr;
	logic [ns-1:0] we_q;

	// Adds an offset to a queue tag and wraps around the queue size
	// Works for queue sizes that are not a power of two as well
	function automatic logic [qw-1:0] tag_add(input logic [qw-1:0] base, input logic [1:0] ofs_in);
		logic [qw:0] sum;
		sum = (qw+1)'(base) + (qw+1)'(ofs_in);
		if (sum >= qentry_count)
			sum = sum - (qw+1)'(qentry_count);
		return sum[qw-1:0];
	endfunction

	// ========================================
	// Slot selection
	// ========================================

	// Valid slots are taken in order while there is free room in the queue
	// A jump or call ends the group after it has been queued
	// Nothing is taken during a branch miss
	always_comb begin
		cnt = 2'd0;
		stop = 1'b0;
		sel = '0;
		ofs = '0;
		for (int i = 0; i < ns; i++) begin
			if (!branchmiss && !stop && slot_v[i] && (cnt < free_cnt)) begin
				sel[i] = 1'b1;
				ofs[i] = cnt;
				cnt = cnt + 2'd1;
				stop = slot_jc[i];
			end
		end
	end

	assign queued_cnt = cnt;

	// Only queued slots that write a register other than r0 count as writes
	always_comb begin
		for (int i = 0; i < ns; i++)
			wr[i] = sel[i] && slot_rfw[i] && (slot_rd[i] != rw'(0));
	end

	// ========================================
	// Tail and held writes
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
			we_q <= '0;
		end else begin
			// cnt is zero on a branch miss so the tail stays put
			tail <= tag_add(tail, cnt);
			we_q <= wr;
		end
	end

	// Destination and tag travel alongside the held enables
	always_ff @(posedge clk) begin
		for (int i = 0; i < ns; i++) begin
			disp_rd[i] <= slot_rd[i];
			disp_tag[i] <= tag_add(tail, ofs[i]);
		end
	end

	// A branch miss in the cycle the writes are presented discards them
	assign disp_we = we_q & ~{ns{branchmiss}};

endmodule

`default_nettype wire

//--- hw/reg_scoreboard_top.sv
// Top level of the register scoreboard; wires dispatch, producer table, ready tracker and APB slave
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard_top #(
	parameter int areg_count = 64,
	parameter int qentry_count = 16
) (
	input  logic clk,
	input  logic rst,
	// Decode slots
	input  logic [regscore_pkg::num_slots-1:0] slot_v,
	input  logic [regscore_pkg::num_slots-1:0] slot_rfw,
	input  logic [regscore_pkg::num_slots-1:0] slot_jc,
	input  logic [regscore_pkg::num_slots-1:0][$clog2(areg_count)-1:0] slot_rd,
	input  logic [1:0] free_cnt,
	output logic [1:0] queued_cnt,
	// Branch recovery
	input  logic branchmiss,
	input  logic [areg_count-1:0] livetarget,
	// Commit ports
	input  logic commit0_v,
	input  logic [$clog2(qentry_count)-1:0] commit0_id,
	input  logic [$clog2(areg_count)-1:0] commit0_tgt,
	input  logic commit1_v,
	input  logic [$clog2(qentry_count)-1:0] commit1_id,
	input  logic [$clog2(areg_count)-1:0] commit1_tgt,
	// APB
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [regscore_pkg::apb_addr_w-1:0] paddr,
	input  logic [regscore_pkg::apb_data_w-1:0] pwdata,
	output logic [regscore_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	// Ready vector
	output logic [areg_count-1:0] rf_v
);

	localparam int ns = regscore_pkg::num_slots;
	localparam int rw = $clog2(areg_count);
	localparam int qw = $clog2(qentry_count);

	// Held dispatch writes shared by the table and the tracker
	logic [ns-1:0] disp_we;
	logic [ns-1:0][rw-1:0] disp_rd;
	logic [ns-1:0][qw-1:0] disp_tag;

	// Producer checks of the commit ports
	logic commit0_match;
	logic commit1_match;

	// Tag lookup for the APB slave
	logic [rw-1:0] src_rd_idx;
	logic [qw-1:0] src_rd_tag;

	// ========================================
	// Input side
	// ========================================

	dispatch_slots #(.areg_count(areg_count), .qentry_count(qentry_count)) u_dispatch (
		.clk(clk), .rst(rst),
		.slot_v(slot_v), .slot_rfw(slot_rfw), .slot_jc(slot_jc), .slot_rd(slot_rd),
		.free_cnt(free_cnt), .branchmiss(branchmiss), .queued_cnt(queued_cnt),
		.disp_we(disp_we), .disp_rd(disp_rd), .disp_tag(disp_tag)
	);

	// ========================================
	// Processing part
	// ========================================

	reg_source_table #(.areg_count(areg_count), .qentry_count(qentry_count)) u_source (
		.clk(clk), .rst(rst),
		.disp_we(disp_we), .disp_rd(disp_rd), .disp_tag(disp_tag),
		.commit0_id(commit0_id), .commit0_tgt(commit0_tgt),
		.commit1_id(commit1_id), .commit1_tgt(commit1_tgt),
		.src_rd_idx(src_rd_idx),
		.commit0_match(commit0_match), .commit1_match(commit1_match),
		.src_rd_tag(src_rd_tag)
	);

	reg_valid_tracker #(.areg_count(areg_count)) u_valid (
		.clk(clk), .rst(rst),
		.disp_we(disp_we), .disp_rd(disp_rd),
		.commit0_v(commit0_v), .commit0_tgt(commit0_tgt), .commit0_match(commit0_match),
		.commit1_v(commit1_v), .commit1_tgt(commit1_tgt), .commit1_match(commit1_match),
		.branchmiss(branchmiss), .livetarget(livetarget), .rf_v(rf_v)
	);

	// ========================================
	// Output side
	// ========================================

	scoreboard_apb #(.areg_count(areg_count), .qentry_count(qentry_count)) u_apb (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.rf_v(rf_v), .src_rd_idx(src_rd_idx), .src_rd_tag(src_rd_tag)
	);

endmodule

`default_nettype wire

//--- hw/reg_source_table.sv
// Producer table of the scoreboard; records each register's producing tag and answers lookups
`timescale 1ns/1ps
`default_nettype none

module reg_source_table #(
	parameter int areg_count = 64,
	parameter int qentry_count = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic [regscore_pkg::num_slots-1:0] disp_we,
	input  logic [regscore_pkg::num_slots-1:0][$clog2(areg_count)-1:0] disp_rd,
	input  logic [regscore_pkg::num_slots-1:0][$clog2(qentry_count)-1:0] disp_tag,
	input  logic [$clog2(qentry_count)-1:0] commit0_id,
	input  logic [$clog2(areg_count)-1:0] commit0_tgt,
	input  logic [$clog2(qentry_count)-1:0] commit1_id,
	input  logic [$clog2(areg_count)-1:0] commit1_tgt,
	input  logic [$clog2(areg_count)-1:0] src_rd_idx,
	output logic commit0_match,
	output logic commit1_match,
	output logic [$clog2(qentry_count)-1:0] src_rd_tag
);

	localparam int ns = regscore_pkg::num_slots;
	localparam int qw = $clog2(qentry_count);

	// One producing queue tag per architectural register
	logic [qw-1:0] src [areg_count];

	// ========================================
	// Dispatch writes
	// ========================================

	// Slots are applied in order so the highest slot naming a register wins
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < areg_count; r++)
				src[r] <= '0;
		end else begin
			for (int i = 0; i < ns; i++) begin
				if (disp_we[i])
					src[disp_rd[i]] <= disp_tag[i];
			end
		end
	end

	// ========================================
	// Lookups
	// ========================================

	// A commit only counts if its tag is still the register's recorded producer
	// A later dispatch to the same register makes an older result stale
	assign commit0_match = (src[commit0_tgt] == commit0_id);
	assign commit1_match = (src[commit1_tgt] == commit1_id);

	// Read port for the APB slave
	assign src_rd_tag = src[src_rd_idx];

endmodule

`default_nettype wire

//--- hw/reg_valid_tracker.sv
// Ready-bit vector of the scoreboard; applies branch restore, commit and dispatch updates
`timescale 1ns/1ps
`default_nettype none

module reg_valid_tracker #(
	parameter int areg_count = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic [regscore_pkg::num_slots-1:0] disp_we,
	input  logic [regscore_pkg::num_slots-1:0][$clog2(areg_count)-1:0] disp_rd,
	input  logic commit0_v,
	input  logic [$clog2(areg_count)-1:0] commit0_tgt,
	input  logic commit0_match,
	input  logic commit1_v,
	input  logic [$clog2(areg_count)-1:0] commit1_tgt,
	input  logic commit1_match,
	input  logic branchmiss,
	input  logic [areg_count-1:0] livetarget,
	output logic [areg_count-1:0] rf_v
);

	localparam int ns = regscore_pkg::num_slots;

	// Next state of the ready vector
	logic [areg_count-1:0] rf_v_nxt;

	// ========================================
	// Update ordering
	// ========================================

	// Each stage starts from the result of the one before it
	// So a later kind of update overrides an earlier one on the same register
	always_comb begin
		rf_v_nxt = rf_v;

		// Branch restore first
		// Registers no live instruction targets any more hold their committed value
		if (branchmiss) begin
			for (int r = 0; r < areg_count; r++) begin
				if (!livetarget[r])
					rf_v_nxt[r] = 1'b1;
			end
		end

		// Commit validation second
		// The producer check guards against a register that was dispatched again meanwhile
		if (commit0_v && commit0_match)
			rf_v_nxt[commit0_tgt] = 1'b1;
		if (commit1_v && commit1_match)
			rf_v_nxt[commit1_tgt] = 1'b1;

		// Dispatch invalidation last
		// The dispatch stage never writes r0 so r0 stays ready
		for (int i = 0; i < ns; i++) begin
			if (disp_we[i])
				rf_v_nxt[disp_rd[i]] = 1'b0;
		end
	end

	// ========================================
	// Ready vector
	// ========================================

	// Every register is ready after reset
	always_ff @(posedge clk) begin
		if (rst)
			rf_v <= '1;
		else
			rf_v <= rf_v_nxt;
	end

endmodule

`default_nettype wire

//--- hw/regscore_pkg.sv
// Shared scoreboard constants; RTL and testbench refer to them by scoped name
`default_nettype none

package regscore_pkg;

	// ========================================
	// Decode front end
	// ========================================

	// Number of decoded instruction slots presented per cycle
	// The slot selection logic in dispatch_slots assumes exactly three
	localparam int num_slots = 3;

	// ========================================
	// APB slave
	// ========================================

	// Byte address width of the APB port
	localparam int apb_addr_w = 12;

	// Read data width, one ready word holds 32 registers
	localparam int apb_data_w = 32;

	// ========================================
	// Address map
	// ========================================

	// Ready-bit words start here
	// Word k covers registers 32k up to 32k+31, bit n of the word is register 32k+n
	localparam logic [apb_addr_w-1:0] valid_base = 12'h000;

	// Producer-tag words start here, one word per register
	// The word at source_base + 4r carries the tag of register r in its low bits
	// Upper bits of a tag word read as zero
	localparam logic [apb_addr_w-1:0] source_base = 12'h400;

	// Any other address, an unaligned address or any write ends with pslverr

endpackage

`default_nettype wire

//--- hw/scoreboard_apb.sv
// Read-only APB slave of the scoreboard; returns ready words and producer tags with one wait state
`timescale 1ns/1ps
`default_nettype none

module scoreboard_apb #(
	parameter int areg_count = 64,
	parameter int qentry_count = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [regscore_pkg::apb_addr_w-1:0] paddr,
	// Write data is ignored since every write is answered with an error
	input  logic [regscore_pkg::apb_data_w-1:0] pwdata,
	output logic [regscore_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic [areg_count-1:0] rf_v,
	output logic [$clog2(areg_count)-1:0] src_rd_idx,
	input  logic [$clog2(qentry_count)-1:0] src_rd_tag
);

	localparam int aw = regscore_pkg::apb_addr_w;
	localparam int dw = regscore_pkg::apb_data_w;
	localparam int rw = $clog2(areg_count);
	localparam int qw = $clog2(qentry_count);
	localparam int word_count = areg_count / 32;
	localparam int widx_w = (word_count > 1) ? $clog2(word_count) : 1;

	// Offsets into each region, they wrap to large values below the base
	logic [aw-1:0] valid_off;
	logic [aw-1:0] src_off;
	logic [widx_w-1:0] widx;
	logic in_valid;
	logic in_src;
	logic err;
	logic [dw-1:0] rd_word;

	// ========================================
	// Address decode
	// ========================================

	assign valid_off = paddr - regscore_pkg::valid_base;
	assign src_off = paddr - regscore_pkg::source_base;
	assign in_valid = (valid_off < aw'(4 * word_count));
	assign in_src = (src_off < aw'(4 * areg_count));

	assign widx = valid_off[widx_w+1:2];
	assign src_rd_idx = src_off[rw+1:2];

	// Writes, holes in the map and unaligned byte addresses all fail
	assign err = pwrite || (paddr[1:0] != 2'b00) || !(in_valid || in_src);

	// Tag words are zero above the tag bits
	assign rd_word = in_valid ? rf_v[int'(widx)*32 +: 32] : {{(dw-qw){1'b0}}, src_rd_tag};

	// ========================================
	// Response
	// ========================================

	// First access cycle latches the lookup, second cycle presents it with pready
	always_ff @(posedge clk) begin
		if (rst) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end else if (pready) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end else if (psel && penable) begin
			pready <= 1'b1;
			pslverr <= err;
		end
	end

	// Error responses carry zero data
	always_ff @(posedge clk) begin
		if (psel && penable && !pready)
			prdata <= err ? '0 : rd_word;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module tb_reg_scoreboard -Mdir obj_dir &&
./obj_dir/Vtb_reg_scoreboard | tee /dev/stderr |
	grep -q "Simulation completed successfully" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }

//--- tb/tb_reg_scoreboard.sv
// Self-checking random testbench for the register scoreboard; compiled with the RTL through compile.f
`timescale 1ns/1ps
`default_nettype none

module tb_reg_scoreboard;

	localparam int ns = regscore_pkg::num_slots;
	localparam int areg_count = 64;
	localparam int qentry_count = 16;
	localparam int rw = $clog2(areg_count);
	localparam int qw = $clog2(qentry_count);
	localparam int aw = regscore_pkg::apb_addr_w;
	localparam int dw = regscore_pkg::apb_data_w;
	localparam int num_cycles = 800;
	localparam int apb_timeout = 8;

	logic clk;
	logic rst;
	logic [ns-1:0] slot_v;
	logic [ns-1:0] slot_rfw;
	logic [ns-1:0] slot_jc;
	logic [ns-1:0][rw-1:0] slot_rd;
	logic [1:0] free_cnt;
	logic [1:0] queued_cnt;
	logic branchmiss;
	logic [areg_count-1:0] livetarget;
	logic commit0_v;
	logic [qw-1:0] commit0_id;
	logic [rw-1:0] commit0_tgt;
	logic commit1_v;
	logic [qw-1:0] commit1_id;
	logic [rw-1:0] commit1_tgt;
	logic psel;
	logic penable;
	logic pwrite;
	logic [aw-1:0] paddr;
	logic [dw-1:0] pwdata;
	logic [dw-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [areg_count-1:0] rf_v;

	// Reference model with the writes the DUT holds for the next cycle
	logic [areg_count-1:0] m_rfv;
	logic [qw-1:0] m_src [areg_count];
	logic [qw-1:0] m_tail;
	logic [ns-1:0] m_we;
	logic [ns-1:0][rw-1:0] m_rd;
	logic [ns-1:0][qw-1:0] m_tag;

	int errors;
	int cycles;
	int apb_count;

	reg_scoreboard_top u_dut (
		.clk(clk), .rst(rst),
		.slot_v(slot_v), .slot_rfw(slot_rfw), .slot_jc(slot_jc), .slot_rd(slot_rd),
		.free_cnt(free_cnt), .queued_cnt(queued_cnt),
		.branchmiss(branchmiss), .livetarget(livetarget),
		.commit0_v(commit0_v), .commit0_id(commit0_id), .commit0_tgt(commit0_tgt),
		.commit1_v(commit1_v), .commit1_id(commit1_id), .commit1_tgt(commit1_tgt),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .rf_v(rf_v)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
		errors++;
		$display("ERR %s expected %h actual %h", name, exp, act);
	endtask

	// Decode, commit and branch inputs quiet
	task automatic set_idle();
		slot_v = '0;
		slot_rfw = '0;
		slot_jc = '0;
		slot_rd = '0;
		free_cnt = 2'd0;
		branchmiss = 1'b0;
		livetarget = '0;
		commit0_v = 1'b0;
		commit0_id = '0;
		commit0_tgt = '0;
		commit1_v = 1'b0;
		commit1_id = '0;
		commit1_tgt = '0;
	endtask

	// ========================================
	// One clock cycle of DUT and model
	// ========================================

	// Entered 2 ns after a rising edge with the inputs in place and left at the same point
	task automatic run_cycle();
		int q;
		logic stopped;
		logic [areg_count-1:0] n_rfv;
		logic [ns-1:0] n_we;
		logic [ns-1:0][rw-1:0] n_rd;
		logic [ns-1:0][qw-1:0] n_tag;
		logic [qw-1:0] n_src [areg_count];
		#3;
		// Slots enter in order while the queue has room and a jump closes the group
		q = 0;
		stopped = 1'b0;
		n_we = '0;
		n_rd = slot_rd;
		n_tag = '0;
		for (int i = 0; i < ns; i++) begin
			if (slot_v[i] && !branchmiss && !stopped && q < int'(free_cnt)) begin
				n_tag[i] = qw'((int'(m_tail) + q) % qentry_count);
				n_we[i] = slot_rfw[i] && (slot_rd[i] != '0);
				q++;
				if (slot_jc[i])
					stopped = 1'b1;
			end
		end
		if (int'(queued_cnt) != q)
			report_mismatch("queued_cnt", 64'(q), 64'(queued_cnt));
		// Restore first, commits second, held dispatch writes last
		n_rfv = m_rfv;
		if (branchmiss)
			n_rfv = n_rfv | ~livetarget;
		if (commit0_v && m_src[commit0_tgt] == commit0_id)
			n_rfv[commit0_tgt] = 1'b1;
		if (commit1_v && m_src[commit1_tgt] == commit1_id)
			n_rfv[commit1_tgt] = 1'b1;
		n_src = m_src;
		if (!branchmiss) begin
			for (int i = 0; i < ns; i++) begin
				if (m_we[i]) begin
					n_rfv[m_rd[i]] = 1'b0;
					n_src[m_rd[i]] = m_tag[i];
				end
			end
		end
		@(posedge clk);
		#1;
		m_rfv = n_rfv;
		m_src = n_src;
		m_tail = qw'((int'(m_tail) + q) % qentry_count);
		m_we = n_we;
		m_rd = n_rd;
		m_tag = n_tag;
		if (rf_v !== m_rfv)
			report_mismatch("rf_v", m_rfv, rf_v);
		cycles++;
		#1;
	endtask

	// Registers 0 to 6 are picked often so that slots collide and redispatch
	task automatic drive_random();
		int r;
		for (int i = 0; i < ns; i++) begin
			r = $urandom % 10;
			slot_rd[i] = (r < 7) ? rw'(r) : rw'($urandom % areg_count);
		end
		slot_v = ns'($urandom);
		slot_rfw = ns'($urandom | $urandom);
		slot_jc = ns'($urandom & $urandom);
		free_cnt = 2'($urandom);
		branchmiss = ($urandom % 12) == 0;
		livetarget = {$urandom, $urandom};
		// Commit ids are the recorded producer or a tag one or two older
		commit0_v = 1'($urandom);
		commit0_tgt = rw'($urandom % 8);
		commit0_id = m_src[commit0_tgt] - qw'($urandom % 3);
		commit1_v = 1'($urandom);
		commit1_tgt = rw'($urandom % 8);
		commit1_id = m_src[commit1_tgt] - qw'($urandom % 3);
	endtask

	// ========================================
	// APB
	// ========================================

	task automatic apb_transfer(input logic [aw-1:0] addr, input logic wr,
			output logic [dw-1:0] act, output logic act_err,
			output logic [dw-1:0] exp, output logic exp_err);
		int waited;
		int a;
		set_idle();
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = $urandom;
		run_cycle();
		// The wait state keeps pready low through the first access cycle
		if (pready !== 1'b0) begin
			errors++;
			$display("pready already high in the first access cycle at address %h", addr);
		end
		penable = 1'b1;
		// The slave looks up the state of the first access cycle
		a = int'(addr);
		exp = '0;
		exp_err = wr || (addr[1:0] != 2'b00);
		if (a >= int'(regscore_pkg::valid_base) && a < int'(regscore_pkg::valid_base) + 8)
			exp = m_rfv[((a - int'(regscore_pkg::valid_base)) / 4) * 32 +: 32];
		else if (a >= int'(regscore_pkg::source_base)
				&& a < int'(regscore_pkg::source_base) + 4 * areg_count)
			exp = dw'(m_src[(a - int'(regscore_pkg::source_base)) / 4]);
		else
			exp_err = 1'b1;
		if (exp_err)
			exp = '0;
		waited = 0;
		do begin
			run_cycle();
			waited++;
		end while (pready !== 1'b1 && waited < apb_timeout);
		if (pready !== 1'b1) begin
			errors++;
			$display("Timeout, no pready within %0d cycles at address %h", apb_timeout, addr);
		end else if (waited != 1) begin
			errors++;
			$display("APB access at address %h took %0d cycles instead of two", addr, waited + 1);
		end
		act = prdata;
		act_err = pslverr;
		run_cycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		apb_count++;
	endtask

	// Random reads of ready and tag words mixed with unaligned, out of range and write accesses
	task automatic apb_random();
		int kind;
		logic wr;
		logic [aw-1:0] addr;
		logic [dw-1:0] act;
		logic [dw-1:0] exp;
		logic act_err;
		logic exp_err;
		kind = $urandom % 6;
		wr = (kind != 0) && ($urandom % 6) == 0;
		if (kind <= 1)
			addr = regscore_pkg::valid_base + aw'(4 * ($urandom % 2));
		else if (kind <= 3)
			addr = regscore_pkg::source_base + aw'(4 * ($urandom % areg_count));
		else if (kind == 4)
			addr = regscore_pkg::source_base + aw'(4 * ($urandom % areg_count) + 1 + $urandom % 3);
		else if ($urandom % 2)
			addr = aw'(12'h008 + 4 * ($urandom % 254));
		else
			addr = aw'(12'h500 + 4 * ($urandom % 704));
		apb_transfer(addr, wr, act, act_err, exp, exp_err);
		if (act_err !== exp_err)
			report_mismatch("apb_pslverr", 64'(exp_err), 64'(act_err));
		if (act !== exp)
			report_mismatch("apb_prdata", 64'(exp), 64'(act));
	endtask

	// ========================================
	// Run
	// ========================================

	initial begin
		logic [dw-1:0] act;
		logic [dw-1:0] exp;
		logic act_err;
		logic exp_err;
		void'($urandom(32'h17aa));
		errors = 0;
		cycles = 0;
		apb_count = 0;
		set_idle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst = 1'b1;
		m_rfv = '1;
		m_tail = '0;
		m_we = '0;
		m_rd = '0;
		m_tag = '0;
		for (int r = 0; r < areg_count; r++)
			m_src[r] = '0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// Everything is ready out of reset on the port and through APB
		if (rf_v !== '1)
			report_mismatch("reset_rf_v", 64'(m_rfv), 64'(rf_v));
		for (int k = 0; k < 2; k++) begin
			apb_transfer(regscore_pkg::valid_base + aw'(4 * k), 1'b0, act, act_err, exp, exp_err);
			if (act_err !== 1'b0)
				report_mismatch("reset_apb_pslverr", 64'(1'b0), 64'(act_err));
			if (act !== 32'hffff_ffff)
				report_mismatch("reset_apb_word", 64'(32'hffff_ffff), 64'(act));
		end

		for (int n = 0; n < num_cycles; n++) begin
			if ($urandom % 12 == 0) begin
				apb_random();
			end else begin
				drive_random();
				run_cycle();
			end
		end
		set_idle();
		run_cycle();
		run_cycle();

		$display("Cycles %0d, APB transfers %0d, errors %0d", cycles, apb_count, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
